/* hw/engine_cfg_pkg.sv */
// Engine configuration types
`default_nettype none

package engine_cfg_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 64;
    localparam int OFFSET_W    = 16;
    localparam int SHIFT_W     = 5;
    localparam int LOCAL_IDX_W = 4;
    localparam int TARGET_W    = 8;

    // Encoded field widths inside a setup word
    localparam int CMD_W       = 2;
    localparam int BUF_CLASS_W = 3;
    localparam int GRAN_W      = DATA_W - 1;

    // ----------------------------------------
    // Enums
    // ----------------------------------------
    typedef enum logic [BUF_CLASS_W-1:0] {
        BUF_INVALID      = 3'd0,
        BUF_CU_SETUP     = 3'd1,
        BUF_ENGINE_SETUP = 3'd2,
        BUF_VERTEX_DATA  = 3'd3,
        BUF_EDGE_DATA    = 3'd4
    } buffer_class_e;

    typedef enum logic [CMD_W-1:0] {
        CMD_INVALID    = 2'd0,
        CMD_READ       = 2'd1,
        CMD_WRITE      = 2'd2,
        CMD_READ_WRITE = 2'd3
    } memory_cmd_e;

    // ----------------------------------------
    // Structs
    // ----------------------------------------

    // One memory response word
    typedef struct packed {
        logic                valid;
        buffer_class_e       buffer_class;
        logic [OFFSET_W-1:0] offset;
        logic [SHIFT_W-1:0]  shift_amount;
        logic [DATA_W-1:0]   data;
    } mem_response_t;

    // Setup word after routing, index is local to the engine window
    typedef struct packed {
        logic [LOCAL_IDX_W-1:0] local_idx;
        logic [DATA_W-1:0]      data;
    } setup_word_t;

    // Read/write configuration of one engine
    typedef struct packed {
        logic                increment;
        logic                decrement;
        logic                mode_sequence;
        logic                mode_buffer;
        logic [DATA_W-1:0]   index_start;
        logic [DATA_W-1:0]   index_end;
        logic [DATA_W-1:0]   stride;
        logic [DATA_W-1:0]   array_size;
        logic [GRAN_W-1:0]   granularity;
        logic                shift_direction;
        memory_cmd_e         cmd;
        buffer_class_e       buffer_class;
        logic [TARGET_W-1:0] target;
        logic [ADDR_W-1:0]   array_pointer;
    } engine_config_t;

    // Output record, source stamp travels beside it
    typedef struct packed {
        logic           valid;
        engine_config_t cfg;
    } config_record_t;

endpackage : engine_cfg_pkg

`default_nettype wire

/* hw/setup_word_router.sv */
// Setup word router
`timescale 1ns/1ps
`default_nettype none

module setup_word_router #(
    parameter int NUM_ENGINES      = 4,
    parameter int ENGINE_SEQ_WIDTH = 16
) (
    input  logic                          ap_clk,
    input  logic                          rst,
    input  engine_cfg_pkg::mem_response_t resp,
    output logic [NUM_ENGINES-1:0]        word_strobe,
    output engine_cfg_pkg::setup_word_t   word
);

    import engine_cfg_pkg::*;

    // Window bounds, ENGINE_SEQ_WIDTH is a power of two
    localparam logic [31:0] SEQ_LIMIT = NUM_ENGINES * ENGINE_SEQ_WIDTH;
    localparam int          SEQ_SHIFT = $clog2(ENGINE_SEQ_WIDTH);
    localparam logic [OFFSET_W-1:0] LOCAL_MASK = OFFSET_W'(ENGINE_SEQ_WIDTH - 1);

    mem_response_t          resp_q;
    logic [OFFSET_W-1:0]    seq_num;
    logic [OFFSET_W-1:0]    engine_idx;
    logic [OFFSET_W-1:0]    local_seq;
    logic                   is_setup;
    logic                   in_window;
    logic                   accept;
    logic [NUM_ENGINES-1:0] strobe_next;
    setup_word_t            word_next;

    // ----------------------------------------
    // Input register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        resp_q <= resp;
        if (rst) begin
            resp_q.valid <= 1'b0;
        end
    end

    // ----------------------------------------
    // Filter and steer
    // ----------------------------------------
    assign seq_num    = resp_q.offset >> resp_q.shift_amount;
    assign engine_idx = seq_num >> SEQ_SHIFT;
    assign local_seq  = seq_num & LOCAL_MASK;

    // Only CU and engine setup classes carry configuration
    assign is_setup  = (resp_q.buffer_class == BUF_CU_SETUP) ||
                       (resp_q.buffer_class == BUF_ENGINE_SETUP);
    assign in_window = 32'(seq_num) < SEQ_LIMIT;
    assign accept    = resp_q.valid && is_setup && in_window;

    always_comb begin
        for (int e = 0; e < NUM_ENGINES; e++) begin
            strobe_next[e] = accept && (engine_idx == OFFSET_W'(e));
        end
    end

    assign word_next.local_idx = LOCAL_IDX_W'(local_seq);
    assign word_next.data      = resp_q.data;

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            word_strobe <= '0;
        end else begin
            word_strobe <= strobe_next;
        end
    end

    // Word goes to every engine, strobe picks the one
    always_ff @(posedge ap_clk) begin
        word <= word_next;
    end

endmodule : setup_word_router

`default_nettype wire

/* hw/engine_config_assembler.sv */
// Engine configuration assembler
`timescale 1ns/1ps
`default_nettype none

module engine_config_assembler (
    input  logic                           ap_clk,
    input  logic                           rst,
    input  logic                           word_strobe,
    input  engine_cfg_pkg::setup_word_t    word,
    output logic                           done,
    output engine_cfg_pkg::engine_config_t cfg
);

    import engine_cfg_pkg::*;

    // ----------------------------------------
    // Local index map
    // ----------------------------------------
    localparam logic [LOCAL_IDX_W-1:0] IDX_FLAGS    = 4'd0;
    localparam logic [LOCAL_IDX_W-1:0] IDX_START    = 4'd1;
    localparam logic [LOCAL_IDX_W-1:0] IDX_END      = 4'd2;
    localparam logic [LOCAL_IDX_W-1:0] IDX_STRIDE   = 4'd3;
    localparam logic [LOCAL_IDX_W-1:0] IDX_GRAN     = 4'd4;
    localparam logic [LOCAL_IDX_W-1:0] IDX_SUBCLASS = 4'd5;
    localparam logic [LOCAL_IDX_W-1:0] IDX_TARGET   = 4'd7;
    localparam logic [LOCAL_IDX_W-1:0] IDX_PTR_LO   = 4'd8;
    localparam logic [LOCAL_IDX_W-1:0] IDX_PTR_HI   = 4'd9;
    localparam logic [LOCAL_IDX_W-1:0] IDX_SIZE     = 4'd10;

    localparam int PTR_HALF = ADDR_W / 2;

    logic started;
    logic is_first;
    logic is_last;

    assign is_first = word_strobe && (word.local_idx == IDX_FLAGS);
    assign is_last  = word_strobe && (word.local_idx == IDX_SIZE);

    // ----------------------------------------
    // Record framing
    // ----------------------------------------
    // Index 0 opens a record, index 10 closes it
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            started <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= is_last && started;
            if (is_last) begin
                started <= 1'b0;
            end else if (is_first) begin
                started <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Field capture
    // ----------------------------------------
    // Fields persist across records, only the indexed one changes
    always_ff @(posedge ap_clk) begin
        if (word_strobe) begin
            case (word.local_idx)
                IDX_FLAGS: begin
                    cfg.increment     <= word.data[0];
                    cfg.decrement     <= word.data[1];
                    cfg.mode_sequence <= word.data[2];
                    cfg.mode_buffer   <= word.data[3];
                end
                IDX_START: begin
                    cfg.index_start <= word.data;
                end
                IDX_END: begin
                    cfg.index_end <= word.data;
                end
                IDX_STRIDE: begin
                    cfg.stride <= word.data;
                end
                IDX_GRAN: begin
                    // Top bit selects the shift direction
                    cfg.granularity     <= word.data[GRAN_W-1:0];
                    cfg.shift_direction <= word.data[DATA_W-1];
                end
                IDX_SUBCLASS: begin
                    cfg.cmd          <= memory_cmd_e'(word.data[CMD_W-1:0]);
                    cfg.buffer_class <=
                        buffer_class_e'(word.data[CMD_W+BUF_CLASS_W-1:CMD_W]);
                end
                IDX_TARGET: begin
                    cfg.target <= word.data[TARGET_W-1:0];
                end
                IDX_PTR_LO: begin
                    cfg.array_pointer[PTR_HALF-1:0] <= word.data;
                end
                IDX_PTR_HI: begin
                    cfg.array_pointer[ADDR_W-1:PTR_HALF] <= word.data;
                end
                IDX_SIZE: begin
                    cfg.array_size <= word.data;
                end
                default: begin
                    // Reserved indices, nothing to store
                end
            endcase
        end
    end

endmodule : engine_config_assembler

`default_nettype wire

/* hw/config_record_collector.sv */
// Configuration record collector
`timescale 1ns/1ps
`default_nettype none

module config_record_collector #(
    parameter int NUM_ENGINES = 4
) (
    input  logic                           ap_clk,
    input  logic                           rst,
    input  logic [NUM_ENGINES-1:0]         done,
    input  engine_cfg_pkg::engine_config_t cfg [NUM_ENGINES],
    output engine_cfg_pkg::config_record_t cfg_out,
    output logic [NUM_ENGINES-1:0]         cfg_source
);

    import engine_cfg_pkg::*;

    engine_config_t sel_cfg;
    logic           any_done;

    // ----------------------------------------
    // Record select
    // ----------------------------------------
    // At most one done per cycle, each tied to its own input word
    always_comb begin
        sel_cfg = '0;
        for (int e = 0; e < NUM_ENGINES; e++) begin
            if (done[e]) begin
                sel_cfg = cfg[e];
            end
        end
    end

    assign any_done = |done;

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        // Last record stays on the bus between strobes
        if (any_done) begin
            cfg_out.cfg <= sel_cfg;
        end
        if (rst) begin
            cfg_out.valid <= 1'b0;
            cfg_source    <= '0;
        end else begin
            cfg_out.valid <= any_done;
            cfg_source    <= done;
        end
    end

endmodule : config_record_collector

`default_nettype wire

/* hw/engine_setup_top.sv */
// Engine setup capture top
`timescale 1ns/1ps
`default_nettype none

module engine_setup_top #(
    parameter int NUM_ENGINES      = 4,
    parameter int ENGINE_SEQ_WIDTH = 16
) (
    input  logic                           ap_clk,
    input  logic                           rst,
    input  engine_cfg_pkg::mem_response_t  resp,
    output engine_cfg_pkg::config_record_t cfg_out,
    output logic [NUM_ENGINES-1:0]         cfg_source
);

    import engine_cfg_pkg::*;

    logic [NUM_ENGINES-1:0] word_strobe;
    setup_word_t            word;
    logic [NUM_ENGINES-1:0] engine_done;
    engine_config_t         engine_cfg [NUM_ENGINES];

    // ----------------------------------------
    // Router
    // ----------------------------------------
    setup_word_router #(
        .NUM_ENGINES      (NUM_ENGINES),
        .ENGINE_SEQ_WIDTH (ENGINE_SEQ_WIDTH)
    ) u_router (
        .ap_clk      (ap_clk),
        .rst         (rst),
        .resp        (resp),
        .word_strobe (word_strobe),
        .word        (word)
    );

    // ----------------------------------------
    // One assembler per engine
    // ----------------------------------------
    for (genvar e = 0; e < NUM_ENGINES; e++) begin : g_engine
        engine_config_assembler u_assembler (
            .ap_clk      (ap_clk),
            .rst         (rst),
            .word_strobe (word_strobe[e]),
            .word        (word),
            .done        (engine_done[e]),
            .cfg         (engine_cfg[e])
        );
    end

    // Collector
    config_record_collector #(
        .NUM_ENGINES (NUM_ENGINES)
    ) u_collector (
        .ap_clk     (ap_clk),
        .rst        (rst),
        .done       (engine_done),
        .cfg        (engine_cfg),
        .cfg_out    (cfg_out),
        .cfg_source (cfg_source)
    );

endmodule : engine_setup_top

`default_nettype wire

/* dv/engine_setup_props.sv */
// Engine setup top assertions
`timescale 1ns/1ps
`default_nettype none

module engine_setup_props #(
    parameter int NUM_ENGINES = 4
) (
    input logic                           ap_clk,
    input logic                           rst,
    input engine_cfg_pkg::config_record_t cfg_out,
    input logic [NUM_ENGINES-1:0]         cfg_source,
    input logic [NUM_ENGINES-1:0]         word_strobe
);

    // Number of failed properties so far
    int fail_count = 0;

    // ----------------------------------------
    // Output record
    // ----------------------------------------
    source_onehot: assert property (@(posedge ap_clk) disable iff (rst)
        cfg_out.valid |-> $onehot(cfg_source))
    else begin
        fail_count++;
        $error("cfg_source is not one-hot while a record is valid");
    end

    // Synchronous reset clears valid on the next edge
    valid_low_in_reset: assert property (@(posedge ap_clk)
        rst |=> !cfg_out.valid)
    else begin
        fail_count++;
        $error("cfg_out.valid is high during reset");
    end

    // ----------------------------------------
    // Router strobe
    // ----------------------------------------
    strobe_onehot0: assert property (@(posedge ap_clk) disable iff (rst)
        $onehot0(word_strobe))
    else begin
        fail_count++;
        $error("word_strobe has more than one bit set");
    end

endmodule : engine_setup_props

bind engine_setup_top engine_setup_props #(
    .NUM_ENGINES (NUM_ENGINES)
) u_props (
    .ap_clk      (ap_clk),
    .rst         (rst),
    .cfg_out     (cfg_out),
    .cfg_source  (cfg_source),
    .word_strobe (word_strobe)
);

`default_nettype wire

/* dv/engine_setup_tb.sv */
// Engine setup capture testbench
`timescale 1ns/1ps
`default_nettype none

module engine_setup_tb;

    import engine_cfg_pkg::*;

    localparam int NUM_ENGINES      = 4;
    localparam int ENGINE_SEQ_WIDTH = 16;
    localparam int SEQ_LIMIT        = NUM_ENGINES * ENGINE_SEQ_WIDTH;
    localparam int RANDOM_CYCLES    = 4000;
    localparam int DRAIN_TIMEOUT    = 50;

    typedef struct packed {
        int                     due;
        logic [NUM_ENGINES-1:0] src;
        engine_config_t         cfg;
    } expected_t;

    logic                   ap_clk;
    logic                   rst;
    mem_response_t          resp;
    config_record_t         cfg_out;
    logic [NUM_ENGINES-1:0] cfg_source;

    // Model state
    engine_config_t model_cfg [NUM_ENGINES];
    logic           model_started [NUM_ENGINES];
    int             next_idx [NUM_ENGINES];
    expected_t      exp_q [$];
    integer         seed;
    int             cycle;
    int             records;
    int             mismatches;
    int             timeouts;

    engine_setup_top DUT (
        .ap_clk     (ap_clk),
        .rst        (rst),
        .resp       (resp),
        .cfg_out    (cfg_out),
        .cfg_source (cfg_source)
    );

    always #5 ap_clk = ~ap_clk;

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    // Offset holds seq shifted up, with random bits below the shift point
    function automatic mem_response_t make_word(input logic [2:0] cls, input int seq,
                                                input int sh);
        mem_response_t r;
        logic [15:0]   low_bits;
        low_bits       = 16'($random(seed)) & ((16'd1 << sh) - 16'd1);
        r.valid        = 1'b1;
        r.buffer_class = buffer_class_e'(cls);
        r.offset       = 16'(seq << sh) | low_bits;
        r.shift_amount = 5'(sh);
        r.data         = $random(seed);
        return r;
    endfunction

    function automatic logic [2:0] setup_class();
        return ($random(seed) & 1) ? BUF_CU_SETUP : BUF_ENGINE_SETUP;
    endfunction

    function automatic mem_response_t idle_word();
        mem_response_t r;
        r       = make_word(setup_class(), $random(seed) & 63, 0);
        r.valid = 1'b0;
        return r;
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    task automatic apply_model(input mem_response_t r, input int sample_cycle);
        int        seq;
        int        e;
        int        idx;
        expected_t exp;
        if (!r.valid) return;
        if (r.buffer_class != BUF_CU_SETUP && r.buffer_class != BUF_ENGINE_SETUP) return;
        seq = int'(r.offset) >> r.shift_amount;
        if (seq >= SEQ_LIMIT) return;
        e   = seq / ENGINE_SEQ_WIDTH;
        idx = seq % ENGINE_SEQ_WIDTH;
        case (idx)
            0: begin
                model_cfg[e].increment     = r.data[0];
                model_cfg[e].decrement     = r.data[1];
                model_cfg[e].mode_sequence = r.data[2];
                model_cfg[e].mode_buffer   = r.data[3];
                model_started[e]           = 1'b1;
            end
            1: model_cfg[e].index_start = r.data;
            2: model_cfg[e].index_end = r.data;
            3: model_cfg[e].stride = r.data;
            4: begin
                model_cfg[e].granularity     = r.data[30:0];
                model_cfg[e].shift_direction = r.data[31];
            end
            5: begin
                model_cfg[e].cmd          = memory_cmd_e'(r.data[1:0]);
                model_cfg[e].buffer_class = buffer_class_e'(r.data[4:2]);
            end
            7: model_cfg[e].target = r.data[7:0];
            8: model_cfg[e].array_pointer[31:0] = r.data;
            9: model_cfg[e].array_pointer[63:32] = r.data;
            10: begin
                model_cfg[e].array_size = r.data;
                if (model_started[e]) begin
                    exp.due = sample_cycle + 3;
                    exp.src = NUM_ENGINES'(1) << e;
                    exp.cfg = model_cfg[e];
                    exp_q.push_back(exp);
                end
                model_started[e] = 1'b0;
            end
            default: ;
        endcase
    endtask

    // ----------------------------------------
    // Per-cycle check and drive
    // ----------------------------------------
    task automatic check_outputs();
        expected_t exp;
        if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
            exp = exp_q.pop_front();
            records++;
            assert (cfg_out.valid === 1'b1) else begin
                mismatches++;
                $display("mismatch at %0t: cfg_out.valid low when a record is due", $time);
            end
            assert (cfg_source === exp.src) else begin
                mismatches++;
                $display("mismatch at %0t: cfg_source %b, expected %b",
                         $time, cfg_source, exp.src);
            end
            assert (cfg_out.cfg === exp.cfg) else begin
                mismatches++;
                $display("mismatch at %0t: record fields %h, expected %h",
                         $time, cfg_out.cfg, exp.cfg);
            end
        end else begin
            assert (cfg_out.valid === 1'b0) else begin
                mismatches++;
                $display("mismatch at %0t: cfg_out.valid high with no record due", $time);
            end
        end
    endtask

    // The word driven now is sampled on the next edge
    task automatic run_cycle(input mem_response_t r);
        @(posedge ap_clk);
        #1;
        cycle++;
        check_outputs();
        resp = r;
        apply_model(r, cycle + 1);
    endtask

    task automatic send_one(input int e, input int idx, input int sh);
        run_cycle(make_word(setup_class(), e * ENGINE_SEQ_WIDTH + idx, sh));
    endtask

    task automatic drain_expected();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
            run_cycle(idle_word());
            waited++;
        end
        if (exp_q.size() > 0) begin
            timeouts++;
            $display("timeout: %0d expected records never appeared", exp_q.size());
            exp_q.delete();
        end
        repeat (5) run_cycle(idle_word());
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int pick;
        int e;
        int idx;
        int sh;
        logic [2:0] cls;
        ap_clk     = 1'b0;
        rst        = 1'b1;
        seed       = 32'h34aa;
        cycle      = 0;
        records    = 0;
        mismatches = 0;
        timeouts   = 0;
        for (int i = 0; i < NUM_ENGINES; i++) begin
            model_cfg[i]     = 'x;
            model_started[i] = 1'b0;
            next_idx[i]      = 0;
        end
        resp = '0;
        repeat (5) @(posedge ap_clk);
        #1;
        rst = 1'b0;

        // Quiet period after reset, then one full record for engine 2
        repeat (10) run_cycle(idle_word());
        for (int i = 0; i <= 10; i++) send_one(2, i, 0);
        drain_expected();

        // Filtered words, a stray close, then a partial record
        run_cycle(make_word(BUF_VERTEX_DATA, 2 * ENGINE_SEQ_WIDTH, 1));
        run_cycle(make_word(BUF_ENGINE_SETUP, SEQ_LIMIT + 2 * ENGINE_SEQ_WIDTH + 3, 0));
        send_one(2, 10, 2);
        for (int i = 0; i <= 2; i++) send_one(2, i, 3);
        send_one(2, 10, 1);
        drain_expected();

        // Random mix of setup bursts, filtered words and idles
        repeat (RANDOM_CYCLES) begin
            pick = $random(seed) & 15;
            if (pick < 9) begin
                e  = $random(seed) & 3;
                sh = $random(seed) & 7;
                if (($random(seed) & 3) != 0) begin
                    idx         = next_idx[e];
                    next_idx[e] = (idx == 10) ? 0 : idx + 1;
                end else begin
                    idx = $random(seed) & 15;
                end
                send_one(e, idx, sh);
            end else if (pick < 11) begin
                case ($random(seed) & 3)
                    0: cls = BUF_INVALID;
                    1: cls = BUF_VERTEX_DATA;
                    2: cls = BUF_EDGE_DATA;
                    default: cls = 3'd7;
                endcase
                run_cycle(make_word(cls, $random(seed) & 63, $random(seed) & 7));
            end else if (pick < 13) begin
                run_cycle(make_word(setup_class(), SEQ_LIMIT + ($random(seed) & 1023),
                                    $random(seed) & 3));
            end else begin
                run_cycle(idle_word());
            end
        end
        drain_expected();

        $display("records=%0d mismatches=%0d timeouts=%0d assertion_failures=%0d",
                 records, mismatches, timeouts, DUT.u_props.fail_count);
        if (mismatches == 0 && timeouts == 0 && DUT.u_props.fail_count == 0 &&
            records > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : engine_setup_tb

`default_nettype wire

/* engine_setup_top.f */
hw/engine_cfg_pkg.sv
hw/setup_word_router.sv
hw/engine_config_assembler.sv
hw/config_record_collector.sv
hw/engine_setup_top.sv
dv/engine_setup_props.sv
dv/engine_setup_tb.sv

/* Bender.yml */
package:
  name: engine_setup

sources:
  # RTL in compile order
  - hw/engine_cfg_pkg.sv
  - hw/setup_word_router.sv
  - hw/engine_config_assembler.sv
  - hw/config_record_collector.sv
  - hw/engine_setup_top.sv

  # Verification
  - target: simulation
    files:
      - dv/engine_setup_props.sv
      - dv/engine_setup_tb.sv
